//--- src/cpuPkg.sv
package cpuPkg;

	typedef logic [31:0] wordT;
	typedef logic [4:0] regAddrT;

	//////////////////////////////
	// Instruction fields

	// Primary opcodes, bits 31:26
	typedef enum logic [5:0] {
		OpSpecial = 6'b000000,
		OpAddi    = 6'b001000,
		OpAndi    = 6'b001100,
		OpOri     = 6'b001101,
		OpLui     = 6'b001111
	} opcodeT;

	// Function codes of the special opcode, bits 5:0
	typedef enum logic [5:0] {
		FnMfhi  = 6'b010000,
		FnMthi  = 6'b010001,
		FnMflo  = 6'b010010,
		FnMtlo  = 6'b010011,
		FnMult  = 6'b011000,
		FnMultu = 6'b011001,
		FnDiv   = 6'b011010,
		FnDivu  = 6'b011011,
		FnAdd   = 6'b100000,
		FnSub   = 6'b100010,
		FnAnd   = 6'b100100,
		FnOr    = 6'b100101,
		FnSlt   = 6'b101010,
		FnSltu  = 6'b101011
	} funcT;

	//////////////////////////////
	// Unit operations

	typedef enum logic [2:0] {
		AluAdd  = 3'b000,
		AluSub  = 3'b001,
		AluOr   = 3'b010,
		AluAnd  = 3'b011,
		AluLui  = 3'b100,
		AluSlt  = 3'b101,
		AluSltu = 3'b110
	} aluOpT;

	typedef enum logic [3:0] {
		MduNone  = 4'd0,
		MduMult  = 4'd1,
		MduMultu = 4'd2,
		MduDiv   = 4'd3,
		MduDivu  = 4'd4,
		MduMfhi  = 4'd5,
		MduMflo  = 4'd6,
		MduMthi  = 4'd7,
		MduMtlo  = 4'd8
	} mduOpT;

	//////////////////////////////
	// Records

	typedef struct packed {
		aluOpT aluOp;
		logic  aluSrcImm; // Immediate replaces rt
		logic  extSigned;
		logic  regDstRd;
		logic  regWrite;
		mduOpT mduOp;
		logic  mduStart; // Multiply or divide begins
		logic  selMdu;   // Data from HI or LO
		logic  illegal;
	} ctrlT;

	typedef struct packed {
		wordT instr;
		wordT rsVal;
		wordT rtVal;
	} issueT;

	typedef struct packed {
		regAddrT regAddr;
		wordT    data;
		logic    regWrite;
		logic    illegal;
	} resultT;

endpackage

//--- src/instrDecoder.sv
module instrDecoder import cpuPkg::*; (
	input  wordT instr,
	output ctrlT ctrl
);

	opcodeT opcode;
	funcT   func;

	assign opcode = opcodeT'(instr[31:26]);
	assign func   = funcT'(instr[5:0]);

	always_comb begin
		// Everything off unless an instruction is recognised
		ctrl.aluOp     = AluAdd;
		ctrl.aluSrcImm = 1'b0;
		ctrl.extSigned = 1'b0;
		ctrl.regDstRd  = 1'b0;
		ctrl.regWrite  = 1'b0;
		ctrl.mduOp     = MduNone;
		ctrl.mduStart  = 1'b0;
		ctrl.selMdu    = 1'b0;
		ctrl.illegal   = 1'b0;

		case (opcode)
			OpSpecial: begin
				case (func)
					FnAdd, FnSub, FnAnd, FnOr, FnSlt, FnSltu: begin
						ctrl.regDstRd = 1'b1;
						ctrl.regWrite = 1'b1;
						case (func)
							FnSub:   ctrl.aluOp = AluSub;
							FnAnd:   ctrl.aluOp = AluAnd;
							FnOr:    ctrl.aluOp = AluOr;
							FnSlt:   ctrl.aluOp = AluSlt;
							FnSltu:  ctrl.aluOp = AluSltu;
							default: ctrl.aluOp = AluAdd;
						endcase
					end
					FnMult: begin
						ctrl.mduOp    = MduMult;
						ctrl.mduStart = 1'b1;
					end
					FnMultu: begin
						ctrl.mduOp    = MduMultu;
						ctrl.mduStart = 1'b1;
					end
					FnDiv: begin
						ctrl.mduOp    = MduDiv;
						ctrl.mduStart = 1'b1;
					end
					FnDivu: begin
						ctrl.mduOp    = MduDivu;
						ctrl.mduStart = 1'b1;
					end
					FnMfhi, FnMflo: begin
						ctrl.mduOp    = (func == FnMfhi) ? MduMfhi : MduMflo;
						ctrl.selMdu   = 1'b1;
						ctrl.regDstRd = 1'b1;
						ctrl.regWrite = 1'b1;
					end
					FnMthi:  ctrl.mduOp = MduMthi; // rs into HI
					FnMtlo:  ctrl.mduOp = MduMtlo;
					default: ctrl.illegal = 1'b1;
				endcase
			end
			OpOri: begin
				ctrl.aluOp     = AluOr;
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite  = 1'b1;
			end
			OpAndi: begin
				ctrl.aluOp     = AluAnd;
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite  = 1'b1;
			end
			OpAddi: begin
				ctrl.aluOp     = AluAdd;
				ctrl.aluSrcImm = 1'b1;
				ctrl.extSigned = 1'b1; // Only signed immediate form
				ctrl.regWrite  = 1'b1;
			end
			OpLui: begin
				ctrl.aluOp     = AluLui;
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite  = 1'b1;
			end
			default: ctrl.illegal = 1'b1;
		endcase
	end

endmodule

//--- src/aluUnit.sv
module aluUnit import cpuPkg::*; (
	input  ctrlT        ctrl,
	input  logic [15:0] imm,
	input  wordT        rsVal,
	input  wordT        rtVal,
	output wordT        aluResult
);

	wordT immExt;
	wordT opB;

	//////////////////////////////
	// Operand selection

	assign immExt = ctrl.extSigned ? {{16{imm[15]}}, imm} : {16'h0000, imm};
	assign opB    = ctrl.aluSrcImm ? immExt : rtVal;

	//////////////////////////////
	// Operation

	always_comb begin
		case (ctrl.aluOp)
			AluAdd:  aluResult = rsVal + opB; // Wraps, no trap
			AluSub:  aluResult = rsVal - opB;
			AluOr:   aluResult = rsVal | opB;
			AluAnd:  aluResult = rsVal & opB;
			AluLui:  aluResult = {opB[15:0], 16'h0000};
			AluSlt: begin
				// Signed compare
				aluResult = {31'd0, $signed(rsVal) < $signed(opB)};
			end
			AluSltu: aluResult = {31'd0, rsVal < opB};
			default: aluResult = '0;
		endcase
	end

endmodule

//--- src/mulDivUnit.sv
module mulDivUnit import cpuPkg::*; #(
	parameter int MulCycles = 5,
	parameter int DivCycles = 10
) (
	input  logic clk,
	input  logic arstN,
	input  ctrlT ctrl,
	input  logic accept,
	input  wordT rsVal,
	input  wordT rtVal,
	output wordT hi,
	output wordT lo,
	output logic mduBusy
);

	localparam int MaxCycles = (MulCycles > DivCycles) ? MulCycles : DivCycles;
	localparam int CntW      = $clog2(MaxCycles + 1);

	logic [CntW-1:0] busyCnt;
	logic            startNow;
	mduOpT           pendOp;
	wordT            opA;
	wordT            opB;
	wordT            newHi;
	wordT            newLo;

	assign startNow = accept && ctrl.mduStart;
	assign mduBusy  = (busyCnt != '0);

	//////////////////////////////
	// Arithmetic on latched operands

	always_comb begin
		newHi = hi;
		newLo = lo;
		case (pendOp)
			MduMult: begin
				{newHi, newLo} = $signed({{32{opA[31]}}, opA}) * $signed({{32{opB[31]}}, opB});
			end
			MduMultu: {newHi, newLo} = {32'd0, opA} * {32'd0, opB};
			MduDiv, MduDivu: begin
				if (opB == '0) begin
					// Divide by zero
					newLo = '1;
					newHi = opA;
				end else if (pendOp == MduDivu) begin
					newLo = opA / opB;
					newHi = opA % opB;
				end else if (opA == 32'h8000_0000 && opB == '1) begin
					newLo = opA; // Signed overflow, quotient wraps
					newHi = '0;
				end else begin
					// Truncates toward zero, remainder takes dividend sign
					newLo = $signed(opA) / $signed(opB);
					newHi = $signed(opA) % $signed(opB);
				end
			end
			default: begin
				newHi = hi;
				newLo = lo;
			end
		endcase
	end

	//////////////////////////////
	// Latency counter and HI/LO

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			busyCnt <= '0;
			hi      <= '0;
			lo      <= '0;
		end else begin
			if (startNow) begin
				if (ctrl.mduOp == MduMult || ctrl.mduOp == MduMultu) begin
					busyCnt <= CntW'(MulCycles);
				end else begin
					busyCnt <= CntW'(DivCycles);
				end
			end else if (mduBusy) begin
				busyCnt <= busyCnt - 1'b1;
			end

			if (busyCnt == CntW'(1)) begin // Commit as busy falls
				hi <= newHi;
				lo <= newLo;
			end else if (accept && ctrl.mduOp == MduMthi) begin
				hi <= rsVal;
			end else if (accept && ctrl.mduOp == MduMtlo) begin
				lo <= rsVal;
			end
		end
	end

	// Operands held for the whole busy window
	always_ff @(posedge clk) begin
		if (startNow) begin
			pendOp <= ctrl.mduOp;
			opA    <= rsVal;
			opB    <= rtVal;
		end
	end

endmodule

//--- src/resultStage.sv
module resultStage import cpuPkg::*; (
	input  logic    clk,
	input  logic    arstN,
	input  logic    issueValid,
	input  ctrlT    ctrl,
	input  regAddrT rtAddr,
	input  regAddrT rdAddr,
	input  wordT    aluResult,
	input  wordT    hi,
	input  wordT    lo,
	input  logic    mduBusy,
	input  logic    resultReady,
	output logic    issueReady,
	output logic    accept,
	output resultT  result,
	output logic    resultValid
);

	logic   usesMdu;
	logic   outFree;
	resultT nextRec;

	//////////////////////////////
	// Stall and acceptance

	assign usesMdu = (ctrl.mduOp != MduNone); // Starts and HI/LO moves
	assign outFree = !resultValid || resultReady;

	// Look at the instruction only while it is presented
	assign issueReady = outFree && !(issueValid && usesMdu && mduBusy);
	assign accept     = issueValid && issueReady;

	//////////////////////////////
	// Record assembly

	always_comb begin
		nextRec.regAddr  = ctrl.regDstRd ? rdAddr : rtAddr;
		nextRec.regWrite = ctrl.regWrite;
		nextRec.illegal  = ctrl.illegal;
		if (!ctrl.regWrite) begin
			nextRec.data = '0; // No write, also covers illegal
		end else if (ctrl.selMdu) begin
			nextRec.data = (ctrl.mduOp == MduMfhi) ? hi : lo;
		end else begin
			nextRec.data = aluResult;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			resultValid <= 1'b0;
		end else if (accept) begin
			resultValid <= 1'b1;
		end else if (resultReady) begin
			resultValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			result <= nextRec;
		end
	end

endmodule

//--- src/execCore.sv
module execCore import cpuPkg::*; #(
	parameter int MulCycles = 5,
	parameter int DivCycles = 10
) (
	input  logic   clk,
	input  logic   arstN,
	input  issueT  issue,
	input  logic   issueValid,
	output logic   issueReady,
	output resultT result,
	output logic   resultValid,
	input  logic   resultReady
);

	ctrlT ctrl;
	wordT aluResult;
	wordT hi;
	wordT lo;
	logic mduBusy;
	logic accept; // Issue transfer this cycle

	instrDecoder decoder (
		.instr (issue.instr),
		.ctrl  (ctrl)
	);

	aluUnit alu (
		.ctrl      (ctrl),
		.imm       (issue.instr[15:0]),
		.rsVal     (issue.rsVal),
		.rtVal     (issue.rtVal),
		.aluResult (aluResult)
	);

	mulDivUnit #(
		.MulCycles (MulCycles),
		.DivCycles (DivCycles)
	) mdu (
		.clk     (clk),
		.arstN   (arstN),
		.ctrl    (ctrl),
		.accept  (accept),
		.rsVal   (issue.rsVal),
		.rtVal   (issue.rtVal),
		.hi      (hi),
		.lo      (lo),
		.mduBusy (mduBusy)
	);

	// rt at 20:16, rd at 15:11
	resultStage stage (
		.clk         (clk),
		.arstN       (arstN),
		.issueValid  (issueValid),
		.ctrl        (ctrl),
		.rtAddr      (issue.instr[20:16]),
		.rdAddr      (issue.instr[15:11]),
		.aluResult   (aluResult),
		.hi          (hi),
		.lo          (lo),
		.mduBusy     (mduBusy),
		.resultReady (resultReady),
		.issueReady  (issueReady),
		.accept      (accept),
		.result      (result),
		.resultValid (resultValid)
	);

endmodule

//--- bench/execCore_assert.sv
module execCoreAssert import cpuPkg::*; (
	input logic   clk,
	input logic   arstN,
	input issueT  issue,
	input logic   issueValid,
	input logic   issueReady,
	input logic   mduBusy,
	input resultT result,
	input logic   resultValid,
	input logic   resultReady
);

	logic hiLoInstr;

	// Class taken from the raw instruction word
	assign hiLoInstr = (issue.instr[31:26] == OpSpecial) &&
		(issue.instr[5:0] inside {FnMult, FnMultu, FnDiv, FnDivu,
			FnMfhi, FnMflo, FnMthi, FnMtlo});

	// Output register empty once reset is seen
	resetClears: assert property (@(posedge clk) !arstN |=> !resultValid)
		else $error("resultValid high right after reset");

	// Held record must not move under back-pressure
	holdUnderStall: assert property (@(posedge clk) disable iff (!arstN)
		resultValid && !resultReady |=> resultValid && $stable(result))
		else $error("Output record changed while resultReady was low");

	noIssueWhileBusy: assert property (@(posedge clk) disable iff (!arstN)
		issueValid && issueReady && hiLoInstr |-> !mduBusy)
		else $error("HI/LO instruction accepted while the multiply/divide unit was busy");

endmodule

bind execCore execCoreAssert checks (
	.clk         (clk),
	.arstN       (arstN),
	.issue       (issue),
	.issueValid  (issueValid),
	.issueReady  (issueReady),
	.mduBusy     (mduBusy),
	.result      (result),
	.resultValid (resultValid),
	.resultReady (resultReady)
);

//--- bench/execCoreTb.sv
module execCoreTb import cpuPkg::*; ();

	localparam int IssueTimeout = 100;
	localparam int DrainTimeout = 400;

	logic   clk;
	logic   arstN;
	issueT  issue;
	logic   issueValid;
	logic   issueReady;
	resultT result;
	logic   resultValid;
	logic   resultReady;

	int     seed = 32'h317d;
	int     readySeed = 32'h317d;
	int     mismatchCount = 0;
	int     otherCount = 0;
	bit     randomReady = 1'b0;
	bit     abortRun = 1'b0; // Set on a timeout, skips the rest
	wordT   refHi = '0;
	wordT   refLo = '0;
	resultT expQ[$];
	resultT expRec;

	logic [5:0]  aluFn[6] = '{FnAdd, FnSub, FnAnd, FnOr, FnSlt, FnSltu};
	logic [5:0]  mdFn[4] = '{FnMult, FnMultu, FnDiv, FnDivu};
	logic [5:0]  moveFn[4] = '{FnMfhi, FnMflo, FnMthi, FnMtlo};
	logic [5:0]  immOps[4] = '{OpOri, OpAndi, OpAddi, OpLui};
	logic [15:0] imms[5] = '{16'hffff, 16'h8000, 16'h7fff, 16'h0000, 16'h1234};
	wordT        opA[6] = '{32'h1234_5678, 32'hffff_fff9, 32'h8000_0000, 32'h0000_0064,
		32'hdead_beef, 32'h7fff_ffff};
	wordT        opB[6] = '{32'h0000_0013, 32'h0000_0002, 32'hffff_ffff, 32'h0000_0000,
		32'hffff_fe0c, 32'h8000_0000};

	execCore #(.MulCycles(5), .DivCycles(10)) DUT (
		.clk         (clk),
		.arstN       (arstN),
		.issue       (issue),
		.issueValid  (issueValid),
		.issueReady  (issueReady),
		.result      (result),
		.resultValid (resultValid),
		.resultReady (resultReady)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//////////////////////////////
	// Reference model

	function automatic resultT expectRecord(input wordT instr, input wordT rs, input wordT rt,
		input wordT hiIn, input wordT loIn);
		resultT rec;
		wordT   immZ;
		wordT   immS;
		rec = '0;
		immZ = {16'h0000, instr[15:0]};
		immS = {{16{instr[15]}}, instr[15:0]};
		rec.regAddr = instr[20:16]; // rt for immediate forms
		rec.regWrite = 1'b1;
		case (instr[31:26])
			OpSpecial: begin
				rec.regAddr = instr[15:11];
				case (instr[5:0])
					FnAdd:  rec.data = rs + rt;
					FnSub:  rec.data = rs - rt;
					FnAnd:  rec.data = rs & rt;
					FnOr:   rec.data = rs | rt;
					FnSlt:  rec.data = ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
					FnSltu: rec.data = (rs < rt) ? 32'd1 : 32'd0;
					FnMfhi: rec.data = hiIn;
					FnMflo: rec.data = loIn;
					FnMult, FnMultu, FnDiv, FnDivu, FnMthi, FnMtlo: rec.regWrite = 1'b0;
					default: begin
						rec.regWrite = 1'b0;
						rec.illegal  = 1'b1;
					end
				endcase
			end
			OpOri:  rec.data = rs | immZ;
			OpAndi: rec.data = rs & immZ;
			OpAddi: rec.data = rs + immS;
			OpLui:  rec.data = {instr[15:0], 16'h0000};
			default: begin
				rec.regWrite = 1'b0;
				rec.illegal  = 1'b1;
			end
		endcase
		return rec;
	endfunction

	task automatic updateHiLo(input wordT instr, input wordT rs, input wordT rt);
		logic [63:0] prod;
		longint      q;
		longint      m;
		if (instr[31:26] == OpSpecial) begin
			case (instr[5:0])
				FnMult: begin
					prod = longint'($signed(rs)) * longint'($signed(rt));
					{refHi, refLo} = prod;
				end
				FnMultu: {refHi, refLo} = {32'd0, rs} * {32'd0, rt};
				FnDiv, FnDivu: begin
					if (rt == '0) begin
						refLo = '1;
						refHi = rs;
					end else if (instr[5:0] == FnDivu) begin
						refLo = rs / rt;
						refHi = rs % rt;
					end else begin
						q = longint'($signed(rs)) / longint'($signed(rt)); // Toward zero
						m = longint'($signed(rs)) % longint'($signed(rt));
						refLo = wordT'(q);
						refHi = wordT'(m);
					end
				end
				FnMthi: refHi = rs;
				FnMtlo: refLo = rs;
				default: ;
			endcase
		end
	endtask

	//////////////////////////////
	// Stimulus helpers

	function automatic wordT rType(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		return {6'b000000, rs, rt, rd, 5'b00000, fn};
	endfunction

	function automatic wordT iType(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic int pick(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [4:0] pickReg();
		return 5'($random(seed));
	endfunction

	task automatic issueInstr(input wordT instr, input wordT rs, input wordT rt);
		int waited;
		if (!abortRun) begin
			@(negedge clk);
			issue = {instr, rs, rt};
			issueValid = 1'b1;
			waited = 0;
			#1; // Past the resultReady update of this edge
			while (!issueReady && waited < IssueTimeout) begin
				@(negedge clk);
				#1;
				waited++;
			end
			if (!issueReady) begin
				$display("Timeout: instruction %h was never accepted", instr);
				otherCount++;
				abortRun = 1'b1;
			end else begin
				expQ.push_back(expectRecord(instr, rs, rt, refHi, refLo));
				updateHiLo(instr, rs, rt);
				@(posedge clk);
			end
		end
	endtask

	task automatic issueRandom(input int kind);
		case (kind)
			0: issueInstr(rType(aluFn[pick(6)], pickReg(), pickReg(), pickReg()),
				$random(seed), $random(seed));
			1: issueInstr(iType(immOps[pick(4)], pickReg(), pickReg(), 16'($random(seed))),
				$random(seed), $random(seed));
			2: issueInstr(rType(mdFn[pick(4)], pickReg(), pickReg(), pickReg()),
				$random(seed), $random(seed));
			default: issueInstr(rType(moveFn[pick(4)], pickReg(), pickReg(), pickReg()),
				$random(seed), $random(seed));
		endcase
	endtask

	task automatic waitDrain();
		int waited;
		waited = 0;
		while (!abortRun && expQ.size() != 0 && waited < DrainTimeout) begin
			@(negedge clk);
			waited++;
		end
		if (!abortRun && expQ.size() != 0) begin
			$display("Timeout: %0d records never came out of the DUT", expQ.size());
			otherCount++;
		end
	endtask

	task automatic checkValue(input string name, input wordT got, input wordT exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			mismatchCount++;
		end
	endtask

	//////////////////////////////
	// Output side

	initial begin
		resultReady = 1'b1;
		forever begin
			@(negedge clk);
			resultReady = !randomReady || ($random(readySeed) % 3 != 0);
		end
	end

	always @(posedge clk) begin
		if (arstN && resultValid && resultReady) begin
			if (expQ.size() == 0) begin
				$display("Record at %0t came out with no instruction waiting for it", $time);
				otherCount++;
			end else begin
				expRec = expQ.pop_front();
				checkValue("result.regWrite", {31'd0, result.regWrite}, {31'd0, expRec.regWrite});
				checkValue("result.illegal", {31'd0, result.illegal}, {31'd0, expRec.illegal});
				checkValue("result.data", result.data, expRec.data);
				if (expRec.regWrite) begin // Address only matters on a write
					checkValue("result.regAddr", {27'd0, result.regAddr}, {27'd0, expRec.regAddr});
				end
			end
		end
	end

	initial begin
		arstN = 1'b0;
		issue = '0;
		issueValid = 1'b0;
		repeat (10) @(negedge clk);
		arstN = 1'b1;

		// ALU edge cases, then random R-type
		issueInstr(rType(FnAdd, 5'd1, 5'd2, 5'd3), 32'h7fff_ffff, 32'h0000_0001);
		issueInstr(rType(FnSub, 5'd4, 5'd5, 5'd6), 32'h8000_0000, 32'h0000_0001);
		issueInstr(rType(FnSlt, 5'd7, 5'd8, 5'd9), 32'hffff_ffff, 32'h0000_0001);
		issueInstr(rType(FnSltu, 5'd7, 5'd8, 5'd10), 32'hffff_ffff, 32'h0000_0001);
		repeat (40) issueRandom(0);

		foreach (immOps[o]) begin
			foreach (imms[i]) begin
				issueInstr(iType(immOps[o], pickReg(), pickReg(), imms[i]), $random(seed), '0);
			end
		end

		// Each multiply or divide read back at once
		foreach (mdFn[f]) begin
			foreach (opA[p]) begin
				issueInstr(rType(mdFn[f], 5'd1, 5'd2, 5'd0), opA[p], opB[p]);
				issueInstr(rType(FnMfhi, 5'd0, 5'd0, pickReg()), $random(seed), $random(seed));
				issueInstr(rType(FnMflo, 5'd0, 5'd0, pickReg()), $random(seed), $random(seed));
			end
		end

		issueInstr(rType(FnMthi, 5'd3, 5'd0, 5'd0), 32'hcafe_f00d, '0);
		issueInstr(rType(FnMtlo, 5'd4, 5'd0, 5'd0), 32'h0bad_beef, '0);
		issueInstr(rType(FnMfhi, 5'd0, 5'd0, 5'd11), '0, '0);
		issueInstr(rType(FnMflo, 5'd0, 5'd0, 5'd12), '0, '0);

		randomReady = 1'b1; // Back-pressure from here on
		repeat (80) issueRandom(pick(4));

		issueInstr({6'h23, 26'h012_3456}, $random(seed), $random(seed));
		issueInstr(rType(6'h08, 5'd1, 5'd2, 5'd3), $random(seed), $random(seed));
		issueInstr(rType(6'h3f, 5'd4, 5'd5, 5'd6), $random(seed), $random(seed));
		issueInstr(rType(FnMfhi, 5'd0, 5'd0, 5'd13), '0, '0);
		issueInstr(rType(FnMflo, 5'd0, 5'd0, 5'd14), '0, '0);

		@(negedge clk);
		issueValid = 1'b0;
		waitDrain();

		$display("Summary: %0d mismatches, %0d other errors", mismatchCount, otherCount);
		if (mismatchCount == 0 && otherCount == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- project.f
src/cpuPkg.sv
src/instrDecoder.sv
src/aluUnit.sv
src/mulDivUnit.sv
src/resultStage.sv
src/execCore.sv
bench/execCore_assert.sv
bench/execCoreTb.sv

//--- Bender.yml
package:
  name: execCore

sources:
  - src/cpuPkg.sv
  - src/instrDecoder.sv
  - src/aluUnit.sv
  - src/mulDivUnit.sv
  - src/resultStage.sv
  - src/execCore.sv
  - target: test
    files:
      - bench/execCore_assert.sv
      - bench/execCoreTb.sv
